//--- common/link_config.svh
`ifndef LINK_CONFIG_SVH
`define LINK_CONFIG_SVH

// Width of the endpoint data word
`define WIDE_LINK_WIDTH 36

// Width of one slice on the narrow link
`define NARROW_LINK_WIDTH 8

// Slices needed to carry one wide word, rounded up
`define SLICE_COUNT ((`WIDE_LINK_WIDTH + `NARROW_LINK_WIDTH - 1) / `NARROW_LINK_WIDTH)

// Width of the wide word once padded to whole slices
`define PADDED_LINK_WIDTH (`SLICE_COUNT * `NARROW_LINK_WIDTH)

`endif

//--- common/link_pkg.sv
`default_nettype none

`include "link_config.svh"

package link_pkg;

  // One slice as it travels on the narrow link
  typedef logic [`NARROW_LINK_WIDTH-1:0] narrow_data_t;

  // Padded wide word seen either as one vector or as its slices
  typedef union packed {
    logic [`PADDED_LINK_WIDTH-1:0] flat;         // Pad and trim boundary
    narrow_data_t [`SLICE_COUNT-1:0] slices;     // Slice 0 in the low bits
  } wide_word_u;

endpackage

`default_nettype wire

//--- common/narrow_link_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

interface narrow_link_if;
  import link_pkg::*;

  // A to B traffic, acknowledged by B
  logic         a_v;
  narrow_data_t a_data;
  logic         b_then_ready;

  // B to A traffic, acknowledged by A
  logic         b_v;
  narrow_data_t b_data;
  logic         a_then_ready;

  modport side_a (
    output a_v, a_data, a_then_ready,
    input  b_v, b_data, b_then_ready
  );

  modport side_b (
    output b_v, b_data, b_then_ready,
    input  a_v, a_data, a_then_ready
  );

endinterface

`default_nettype wire

//--- hw/serdes/link_piso.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_piso (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire                    wide_valid_i,
  input  link_pkg::wide_word_u   wide_data_i,
  output logic                   wide_ready_o,
  output logic                   narrow_v_o,
  output link_pkg::narrow_data_t narrow_data_o,
  input  wire                    narrow_then_ready_i
);
  import link_pkg::*;

  localparam int idx_bits_lp = $clog2(`SLICE_COUNT);

  logic                   held_r;   // A word is being sent
  logic [idx_bits_lp-1:0] idx_r;    // Slice currently on the link
  wide_word_u             word_r;
  logic                   last_slice;
  logic                   accept;

  assign last_slice = (idx_r == idx_bits_lp'(`SLICE_COUNT - 1));

  // Free again once the final slice is acknowledged
  assign wide_ready_o = ~held_r | (narrow_then_ready_i & last_slice);
  assign accept       = wide_valid_i & wide_ready_o;

  assign narrow_v_o    = held_r;
  assign narrow_data_o = word_r.slices[idx_r];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      held_r <= 1'b0;
      idx_r  <= '0;
    end else if (accept) begin
      held_r <= 1'b1;
      idx_r  <= '0;                 // Slice 0 shows next cycle
    end else if (held_r && narrow_then_ready_i) begin
      if (last_slice) begin
        held_r <= 1'b0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_r <= wide_data_i;
    end
  end

  // The receiver may look at the slice over several cycles before acking it
  a_slice_held : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    narrow_v_o && !narrow_then_ready_i |=> narrow_v_o && $stable(narrow_data_o)
  );

endmodule

`default_nettype wire

//--- hw/serdes/link_sipo.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_sipo (
  input  wire                    clk_i,
  input  wire                    rst_n_i,
  input  wire                    narrow_v_i,
  input  link_pkg::narrow_data_t narrow_data_i,
  output logic                   narrow_ready_o,
  output logic                   wide_valid_o,
  output link_pkg::wide_word_u   wide_data_o,
  input  wire                    wide_ready_i
);
  import link_pkg::*;

  localparam int cnt_bits_lp = $clog2(`SLICE_COUNT + 1);
  localparam int idx_bits_lp = $clog2(`SLICE_COUNT);

  logic [cnt_bits_lp-1:0] count_r;  // Slices gathered so far
  wide_word_u             word_r;
  logic                   full;
  logic                   accept;
  logic                   take;
  logic [idx_bits_lp-1:0] wr_idx;

  assign full = (count_r == cnt_bits_lp'(`SLICE_COUNT));

  // Room when not full, or when the full word leaves this cycle
  assign narrow_ready_o = ~full | wide_ready_i;
  assign accept         = narrow_v_i & narrow_ready_o;
  assign take           = full & wide_ready_i;

  // A slice arriving as the word leaves starts the next word
  assign wr_idx = full ? '0 : count_r[idx_bits_lp-1:0];

  assign wide_valid_o = full;
  assign wide_data_o  = word_r;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      count_r <= '0;
    end else if (take) begin
      count_r <= accept ? cnt_bits_lp'(1) : '0;
    end else if (accept) begin
      count_r <= count_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      word_r.slices[wr_idx] <= narrow_data_i;
    end
  end

  // Offered word must wait for the consumer unchanged
  a_wide_held : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    wide_valid_o && !wide_ready_i |=> wide_valid_o && $stable(wide_data_o)
  );

endmodule

`default_nettype wire

//--- hw/wide_link_adapter.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module wide_link_adapter #(
  parameter bit side_b_p = 1'b0     // Which end of the narrow link this is
) (
  input  wire                         clk_i,
  input  wire                         rst_n_i,
  input  wire                         tx_valid_i,
  input  wire  [`WIDE_LINK_WIDTH-1:0] tx_data_i,
  output logic                        tx_ready_o,
  output logic                        rx_valid_o,
  output logic [`WIDE_LINK_WIDTH-1:0] rx_data_o,
  input  wire                         rx_ready_i,
  narrow_link_if                      link_io
);
  import link_pkg::*;

  localparam int pad_bits_lp = `PADDED_LINK_WIDTH - `WIDE_LINK_WIDTH;

  wide_word_u   tx_word;
  wide_word_u   rx_word;
  logic         tx_v;
  narrow_data_t tx_data;
  logic         tx_then_ready;
  logic         rx_v;
  narrow_data_t rx_data;
  logic         rx_then_ready;
  logic         sipo_ready;

  assign tx_word.flat = `PADDED_LINK_WIDTH'(tx_data_i);          // Zero pad on top
  assign rx_data_o    = rx_word.flat[`WIDE_LINK_WIDTH-1:0];      // Drop the pad

  // Ack only a slice that is present and fits
  assign rx_then_ready = rx_v & sipo_ready;

  // Map this end's view of the narrow link onto local names
  if (side_b_p) begin : g_side_b
    assign link_io.b_v          = tx_v;
    assign link_io.b_data       = tx_data;
    assign link_io.b_then_ready = rx_then_ready;
    assign tx_then_ready        = link_io.a_then_ready;
    assign rx_v                 = link_io.a_v;
    assign rx_data              = link_io.a_data;
  end else begin : g_side_a
    assign link_io.a_v          = tx_v;
    assign link_io.a_data       = tx_data;
    assign link_io.a_then_ready = rx_then_ready;
    assign tx_then_ready        = link_io.b_then_ready;
    assign rx_v                 = link_io.b_v;
    assign rx_data              = link_io.b_data;
  end

  link_piso piso_i (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .wide_valid_i       (tx_valid_i),
    .wide_data_i        (tx_word),
    .wide_ready_o       (tx_ready_o),
    .narrow_v_o         (tx_v),
    .narrow_data_o      (tx_data),
    .narrow_then_ready_i(tx_then_ready)
  );

  link_sipo sipo_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .narrow_v_i    (rx_v),
    .narrow_data_i (rx_data),
    .narrow_ready_o(sipo_ready),
    .wide_valid_o  (rx_valid_o),
    .wide_data_o   (rx_word),
    .wide_ready_i  (rx_ready_i)
  );

  // Far end pads with zeros, so a gathered word never carries pad bits
  a_pad_clear : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    rx_valid_o |-> rx_word.flat[`PADDED_LINK_WIDTH-1 -: pad_bits_lp] == '0
  );

endmodule

`default_nettype wire

//--- hw/link_pair_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_pair_top (
  input  wire                         clk_i,
  input  wire                         rst_n_i,

  // Endpoint A
  input  wire                         a_tx_valid_i,
  input  wire  [`WIDE_LINK_WIDTH-1:0] a_tx_data_i,
  output logic                        a_tx_ready_o,
  output logic                        a_rx_valid_o,
  output logic [`WIDE_LINK_WIDTH-1:0] a_rx_data_o,
  input  wire                         a_rx_ready_i,

  // Endpoint B
  input  wire                         b_tx_valid_i,
  input  wire  [`WIDE_LINK_WIDTH-1:0] b_tx_data_i,
  output logic                        b_tx_ready_o,
  output logic                        b_rx_valid_o,
  output logic [`WIDE_LINK_WIDTH-1:0] b_rx_data_o,
  input  wire                         b_rx_ready_i
);

  // Both directions share this one bundle
  narrow_link_if link_if ();

  wide_link_adapter #(
    .side_b_p(1'b0)
  ) adapter_a_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tx_valid_i(a_tx_valid_i),
    .tx_data_i (a_tx_data_i),
    .tx_ready_o(a_tx_ready_o),
    .rx_valid_o(a_rx_valid_o),
    .rx_data_o (a_rx_data_o),
    .rx_ready_i(a_rx_ready_i),
    .link_io   (link_if.side_a)
  );

  wide_link_adapter #(
    .side_b_p(1'b1)
  ) adapter_b_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tx_valid_i(b_tx_valid_i),
    .tx_data_i (b_tx_data_i),
    .tx_ready_o(b_tx_ready_o),
    .rx_valid_o(b_rx_valid_o),
    .rx_data_o (b_rx_data_o),
    .rx_ready_i(b_rx_ready_i),
    .link_io   (link_if.side_b)
  );

endmodule

`default_nettype wire

//--- testbench/link_pair_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "link_config.svh"

module link_pair_tb;

  localparam int words_lp   = 200;
  localparam int timeout_lp = words_lp * 6 * 4 + 1200;  // Slowest stream with back-pressure
  localparam logic [31:0] seed_lp = 32'h1e37bce3;

  logic                        clk_i = 1'b0;
  logic                        rst_n_i;
  logic                        a_tx_valid_i;
  logic [`WIDE_LINK_WIDTH-1:0] a_tx_data_i;
  logic                        a_tx_ready_o;
  logic                        a_rx_valid_o;
  logic [`WIDE_LINK_WIDTH-1:0] a_rx_data_o;
  logic                        a_rx_ready_i;
  logic                        b_tx_valid_i;
  logic [`WIDE_LINK_WIDTH-1:0] b_tx_data_i;
  logic                        b_tx_ready_o;
  logic                        b_rx_valid_o;
  logic [`WIDE_LINK_WIDTH-1:0] b_rx_data_o;
  logic                        b_rx_ready_i;
  logic [3:0]                  idle_status;

  logic [`WIDE_LINK_WIDTH-1:0] ab_q[$];   // Sent by A, not yet seen at B
  logic [`WIDE_LINK_WIDTH-1:0] ba_q[$];
  logic [`WIDE_LINK_WIDTH-1:0] ab_head = '0;
  logic [`WIDE_LINK_WIDTH-1:0] ba_head = '0;
  int          ab_pending = 0;
  int          ba_pending = 0;
  int          a_acc_cnt = 0;
  int          b_acc_cnt = 0;
  int          ab_rx_cnt = 0;
  int          ba_rx_cnt = 0;
  int          cycle = 0;
  int          sent_cycle = 0;
  int          errors = 0;
  int          err_base = 0;
  int          ab_base = 0;
  int          ba_base = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  string       test_name = "reset_state";
  logic        bp_mode = 1'b0;
  logic        latency_mode = 1'b0;
  logic        idle_check = 1'b0;
  logic [31:0] ab_state;
  logic [31:0] ba_state;
  logic [31:0] rdy_state;

  assign idle_status = {a_rx_valid_o, b_rx_valid_o, a_tx_ready_o, b_tx_ready_o};

  link_pair_top dut_i (.*);

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Every fourth word sets the top nibble that the pad sits above
  function automatic logic [`WIDE_LINK_WIDTH-1:0] make_word(inout logic [31:0] s, input int n);
    logic [`WIDE_LINK_WIDTH-1:0] w;
    logic [31:0]                 lo;
    s  = lcg(s);
    lo = s;
    s  = lcg(s);
    w  = `WIDE_LINK_WIDTH'({s, lo});
    if (n % 4 == 0) begin
      w[`WIDE_LINK_WIDTH-1 -: 4] = 4'hf;
    end
    return w;
  endfunction

  // Scoreboard, head and count go out by NBA so checks see pre-edge state
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (rst_n_i) begin
      if (a_tx_valid_i && a_tx_ready_o) begin
        ab_q.push_back(a_tx_data_i);
        a_acc_cnt <= a_acc_cnt + 1;
        sent_cycle = cycle;
      end
      if (b_tx_valid_i && b_tx_ready_o) begin
        ba_q.push_back(b_tx_data_i);
        b_acc_cnt <= b_acc_cnt + 1;
      end
      if (b_rx_valid_o && b_rx_ready_i) begin
        if (ab_q.size() > 0) void'(ab_q.pop_front());
        ab_rx_cnt <= ab_rx_cnt + 1;
        if (latency_mode) begin
          latency_ok : assert (cycle - sent_cycle == 6) else begin
            errors++;
            $display("[FAIL] %s expected %0d actual %0d", test_name, 6, cycle - sent_cycle);
          end
        end
      end
      if (a_rx_valid_o && a_rx_ready_i) begin
        if (ba_q.size() > 0) void'(ba_q.pop_front());
        ba_rx_cnt <= ba_rx_cnt + 1;
      end
      ab_pending <= ab_q.size();
      ba_pending <= ba_q.size();
      ab_head    <= (ab_q.size() > 0) ? ab_q[0] : '0;
      ba_head    <= (ba_q.size() > 0) ? ba_q[0] : '0;
    end
  end

  always @(posedge clk_i) begin
    if (cycle >= timeout_lp) begin
      $display("Timeout in %s: run did not finish within %0d cycles", test_name, timeout_lp);
      $display("Errors found");
      $finish;
    end
  end

  // Random receiver stalls on both sides
  always @(negedge clk_i) begin
    if (bp_mode) begin
      rdy_state    = lcg(rdy_state);
      a_rx_ready_i = rdy_state[20];
      rdy_state    = lcg(rdy_state);
      b_rx_ready_i = rdy_state[20];
    end else begin
      a_rx_ready_i = 1'b1;
      b_rx_ready_i = 1'b1;
    end
  end

  a_idle_state : assert property (
    @(posedge clk_i) idle_check |-> idle_status == 4'b0011
  ) else begin
    errors++;
    $display("[FAIL] %s expected %b actual %b", test_name, 4'b0011, $sampled(idle_status));
  end

  a_ab_order : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    b_rx_valid_o && b_rx_ready_i |-> ab_pending != 0 && b_rx_data_o == ab_head
  ) else begin
    errors++;
    $display("[FAIL] %s expected %h actual %h", test_name, $sampled(ab_head),
             $sampled(b_rx_data_o));
  end

  a_ba_order : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    a_rx_valid_o && a_rx_ready_i |-> ba_pending != 0 && a_rx_data_o == ba_head
  ) else begin
    errors++;
    $display("[FAIL] %s expected %h actual %h", test_name, $sampled(ba_head),
             $sampled(a_rx_data_o));
  end

  a_b_rx_hold : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    b_rx_valid_o && !b_rx_ready_i |=> b_rx_valid_o && $stable(b_rx_data_o)
  ) else begin
    errors++;
    $display("%s: word at B was dropped or changed before it was taken", test_name);
  end

  // Called on a falling edge, returns on one
  task automatic send_from_a(input int n);
    int target;
    for (int i = 0; i < n; i++) begin
      a_tx_data_i  = make_word(ab_state, i);
      a_tx_valid_i = 1'b1;
      target       = a_acc_cnt + 1;
      do @(negedge clk_i); while (a_acc_cnt != target);
    end
    a_tx_valid_i = 1'b0;
  endtask

  task automatic send_from_b(input int n);
    int target;
    for (int i = 0; i < n; i++) begin
      b_tx_data_i  = make_word(ba_state, i);
      b_tx_valid_i = 1'b1;
      target       = b_acc_cnt + 1;
      do @(negedge clk_i); while (b_acc_cnt != target);
    end
    b_tx_valid_i = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    err_base  = errors;
    ab_base   = ab_rx_cnt;
    ba_base   = ba_rx_cnt;
  endtask

  task automatic end_test(input int ab_exp, input int ba_exp);
    while (ab_pending != 0 || ba_pending != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    ab_count_ok : assert (ab_rx_cnt - ab_base == ab_exp) else begin
      errors++;
      $display("[FAIL] %s expected %0d actual %0d", test_name, ab_exp, ab_rx_cnt - ab_base);
    end
    ba_count_ok : assert (ba_rx_cnt - ba_base == ba_exp) else begin
      errors++;
      $display("[FAIL] %s expected %0d actual %0d", test_name, ba_exp, ba_rx_cnt - ba_base);
    end
    tests_run++;
    if (errors == err_base) begin
      $display("Test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("Test %s failed with %0d errors", test_name, errors - err_base);
    end
  endtask

  initial begin
    rst_n_i      = 1'b0;
    a_tx_valid_i = 1'b0;
    a_tx_data_i  = '0;
    a_rx_ready_i = 1'b1;
    b_tx_valid_i = 1'b0;
    b_tx_data_i  = '0;
    b_rx_ready_i = 1'b1;
    ab_state     = seed_lp;
    ba_state     = lcg(seed_lp ^ 32'h5a5a_5a5a);
    rdy_state    = lcg(~seed_lp);
    start_test("reset_state");
    repeat (2) @(negedge clk_i);
    idle_check = 1'b1;                // Outputs settled after first edge
    repeat (14) @(negedge clk_i);
    rst_n_i = 1'b1;
    repeat (4) @(negedge clk_i);
    idle_check = 1'b0;
    end_test(0, 0);
    start_test("a_to_b_stream");
    send_from_a(words_lp);
    end_test(words_lp, 0);
    start_test("both_directions");
    fork
      send_from_a(words_lp);
      send_from_b(words_lp);
    join
    end_test(words_lp, words_lp);
    start_test("back_pressure");
    bp_mode = 1'b1;
    fork
      send_from_a(words_lp);
      send_from_b(words_lp);
    join
    end_test(words_lp, words_lp);
    bp_mode = 1'b0;
    repeat (2) @(negedge clk_i);
    start_test("idle_latency");
    latency_mode = 1'b1;
    send_from_a(1);
    end_test(1, 0);
    latency_mode = 1'b0;
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/link_pkg.sv
common/narrow_link_if.sv
hw/serdes/link_piso.sv
hw/serdes/link_sipo.sv
hw/wide_link_adapter.sv
hw/link_pair_top.sv
testbench/link_pair_tb.sv

//--- Makefile
TOP := link_pair_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f files.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^No errors$$" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module link_pair_top -f files.f

clean:
	rm -rf obj_dir $(LOG)
